// ==== cpu_defs.svh ====
// rv32i pipeline core global sizes
// data width, register count, memory depths and the bubble word

`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath and address width
`define XLEN 32

// architectural registers x0..x31
`define REG_COUNT 32

// instruction memory size in words
`define IMEM_DEPTH 256

// data memory size in words
`define DMEM_DEPTH 256

`define NOP_INSTR 32'h0000_0013 // addi x0, x0, 0

`endif

// ==== cpu_pkg.sv ====
// rv32i pipeline core shared types
// opcode values, decoded control word, stage-boundary records and port records

`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0]               word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0]  reg_addr_t;

    // major opcodes of the supported subset
    localparam logic [6:0] op_reg    = 7'b0110011; // add sub and or slt
    localparam logic [6:0] op_imm    = 7'b0010011; // addi
    localparam logic [6:0] op_load   = 7'b0000011; // lw
    localparam logic [6:0] op_store  = 7'b0100011; // sw
    localparam logic [6:0] op_branch = 7'b1100011; // beq bne
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011; // ecall, treated as halt

    typedef enum logic [2:0] {
        alu_add = 3'd0, // zero value, so a cleared ctrl is a bubble
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_e;

    // ==============================
    // decoded control, travels with each instruction
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;   // operand b from immediate
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;      // jal
        logic    mem_write;
        logic    mem_read;
        logic    reg_write;
        logic    sel_link;  // write back pc + 4
        logic    halt;
    } ctrl_t;

    // ==============================
    // pipeline registers between stages
    typedef struct packed {
        word_t instr;
        word_t pc;
    } fd_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
    } de_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     alu_result; // also the data memory address
        word_t     store_data;
        word_t     link_pc;
        reg_addr_t rd;
    } em_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     load_data;
        word_t     link_pc;
        reg_addr_t rd;
    } mw_t;

    // register file write, also brought out for observation
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    // program load strobe into instruction memory
    typedef struct packed {
        logic                            valid;
        logic [$clog2(`IMEM_DEPTH)-1:0]  addr;  // word index
        word_t                           data;
    } imem_load_t;

endpackage

// ==== instr_decoder.sv ====
// direct instruction decoder
// maps the supported rv32i opcodes onto the control word and builds the immediate

`timescale 1ns/1ps

module instr_decoder
    import cpu_pkg::*;
(
    input  word_t     instr,
    output ctrl_t     ctrl,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output word_t     imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // register fields sit in fixed places for every format
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    always_comb begin
        ctrl = '0;                                        // bubble unless matched below
        imm  = {{20{instr[31]}}, instr[31:20]};           // i-type by default
        case (opcode)
            op_reg: begin
                if (funct7 == 7'b0000000 || (funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    ctrl.reg_write = 1'b1;
                    case (funct3)
                        3'b000:  ctrl.alu_op = funct7[5] ? alu_sub : alu_add;
                        3'b111:  ctrl.alu_op = alu_and;
                        3'b110:  ctrl.alu_op = alu_or;
                        3'b010:  ctrl.alu_op = alu_slt;
                        default: ctrl = '0;               // unsupported r-type
                    endcase
                end
            end
            op_imm: begin
                if (funct3 == 3'b000) begin               // addi only
                    ctrl.use_imm   = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
            end
            op_load: begin
                if (funct3 == 3'b010) begin               // lw
                    ctrl.use_imm   = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
            end
            op_store: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                if (funct3 == 3'b010) begin               // sw
                    ctrl.use_imm   = 1'b1;
                    ctrl.mem_write = 1'b1;
                end
            end
            op_branch: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                ctrl.branch_eq = (funct3 == 3'b000);
                ctrl.branch_ne = (funct3 == 3'b001);
            end
            op_jal: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.sel_link  = 1'b1;                    // rd gets pc + 4
            end
            op_system: ctrl.halt = 1'b1;                  // ecall stops the core
            default:   ctrl = '0;
        endcase
    end

endmodule

// ==== reg_file.sv ====
// integer register file
// two asynchronous reads, one write from the writeback bus, x0 reads as zero

`timescale 1ns/1ps
`include "cpu_defs.svh"

module reg_file
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  wb_t       wb
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1]; // x0 hardwired
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== fetch_stage.sv ====
// fetch stage
// program counter, loadable instruction memory and the fetch/decode register

`timescale 1ns/1ps
`include "cpu_defs.svh"

module fetch_stage
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  imem_load_t imem_load,
    input  logic       redirect,   // taken branch or jump from execute
    input  word_t      target_pc,
    input  logic       halt_seen,  // ecall already decoded
    output fd_t        fd
);

    localparam int unsigned imem_aw = $clog2(`IMEM_DEPTH);

    word_t imem [`IMEM_DEPTH];
    word_t pc;
    word_t instr;

    // program load port, only used while the core sits in reset
    always_ff @(posedge clk) begin
        if (imem_load.valid) begin
            imem[imem_load.addr] <= imem_load.data;
        end
    end

    assign instr = imem[pc[imem_aw+1:2]]; // word addressed, async read

    // next pc, redirect wins over the halt hold
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= target_pc;
        end else if (!halt_seen) begin
            pc <= pc + word_t'(4);
        end
    end

    // wrong-path or post-halt fetch goes down as a nop
    always_ff @(posedge clk) begin
        if (reset) begin
            fd.instr <= `NOP_INSTR;
            fd.pc    <= '0;
        end else begin
            fd.instr <= (redirect || halt_seen) ? `NOP_INSTR : instr;
            fd.pc    <= pc;
        end
    end

endmodule

// ==== decode_stage.sv ====
// decode stage
// flushes on redirect, reads registers with writeback bypass, latches halt,
// and loads the decode/execute register

`timescale 1ns/1ps
`include "cpu_defs.svh"

module decode_stage
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  fd_t   fd,
    input  logic  redirect,
    input  wb_t   wb,
    output de_t   de,
    output logic  halt_seen
);

    word_t     instr;
    ctrl_t     ctrl;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    word_t     rs1_raw;
    word_t     rs2_raw;

    // younger than a taken branch or an ecall, so squash
    assign instr = (redirect || halt_seen) ? `NOP_INSTR : fd.instr;

    instr_decoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .imm   (imm)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_raw),
        .rs2_data (rs2_raw),
        .wb       (wb)
    );

    // sticky once an ecall has been decoded
    always_ff @(posedge clk) begin
        if (reset) begin
            halt_seen <= 1'b0;
        end else if (ctrl.halt) begin
            halt_seen <= 1'b1;
        end
    end

    // ==============================
    // decode/execute register
    always_ff @(posedge clk) begin
        if (reset) begin
            de.ctrl <= '0;
        end else begin
            de.ctrl <= ctrl;
        end
        de.pc       <= fd.pc;
        // same-cycle writeback bypass, valid never carries x0
        de.rs1_data <= (wb.valid && wb.rd == rs1) ? wb.data : rs1_raw;
        de.rs2_data <= (wb.valid && wb.rd == rs2) ? wb.data : rs2_raw;
        de.imm      <= imm;
        de.rs1      <= rs1;
        de.rs2      <= rs2;
        de.rd       <= rd;
    end

endmodule

// ==== execute_stage.sv ====
// execute stage
// operand forwarding, alu, branch and jump resolution, execute/memory register

`timescale 1ns/1ps

module execute_stage
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  de_t   de,
    input  em_t   mem_fwd,    // instruction now in the memory stage
    input  word_t load_data,  // its async load result
    input  wb_t   wb_fwd,     // instruction now in writeback
    output logic  redirect,
    output word_t target_pc,
    output em_t   em
);

    word_t mem_value;
    logic  mem_hit1;
    logic  mem_hit2;
    word_t op1;
    word_t op2;
    word_t alu_b;
    word_t alu_result;
    logic  equal;

    // value the memory-stage instruction will write
    assign mem_value = mem_fwd.ctrl.mem_read ? load_data :
                       mem_fwd.ctrl.sel_link ? mem_fwd.link_pc : mem_fwd.alu_result;

    assign mem_hit1 = mem_fwd.ctrl.reg_write && mem_fwd.rd != '0 && mem_fwd.rd == de.rs1;
    assign mem_hit2 = mem_fwd.ctrl.reg_write && mem_fwd.rd != '0 && mem_fwd.rd == de.rs2;

    // ==============================
    // forwarding, nearest producer first
    always_comb begin
        if (mem_hit1) begin
            op1 = mem_value;
        end else if (wb_fwd.valid && wb_fwd.rd == de.rs1) begin
            op1 = wb_fwd.data;
        end else begin
            op1 = de.rs1_data;            // already bypassed in decode
        end
        if (mem_hit2) begin
            op2 = mem_value;
        end else if (wb_fwd.valid && wb_fwd.rd == de.rs2) begin
            op2 = wb_fwd.data;
        end else begin
            op2 = de.rs2_data;
        end
    end

    assign alu_b = de.ctrl.use_imm ? de.imm : op2;

    always_comb begin
        case (de.ctrl.alu_op)
            alu_sub: alu_result = op1 - alu_b;
            alu_and: alu_result = op1 & alu_b;
            alu_or:  alu_result = op1 | alu_b;
            alu_slt: alu_result = word_t'($signed(op1) < $signed(alu_b));
            default: alu_result = op1 + alu_b; // add, address calc, bubbles
        endcase
    end

    // branches compare the register operands, never the immediate
    assign equal     = (op1 == op2);
    assign redirect  = (de.ctrl.branch_eq && equal) ||
                       (de.ctrl.branch_ne && !equal) ||
                       de.ctrl.jump;
    assign target_pc = de.pc + de.imm;  // pc relative for beq, bne and jal

    // ==============================
    // execute/memory register
    always_ff @(posedge clk) begin
        if (reset) begin
            em.ctrl <= '0;
        end else begin
            em.ctrl <= de.ctrl;
        end
        em.alu_result <= alu_result;
        em.store_data <= op2;               // forwarded store value
        em.link_pc    <= de.pc + word_t'(4);
        em.rd         <= de.rd;
    end

endmodule

// ==== memory_stage.sv ====
// memory stage and writeback
// data memory, memory/writeback register, writeback select and the halt flag

`timescale 1ns/1ps
`include "cpu_defs.svh"

module memory_stage
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  em_t   em,
    output word_t load_data,  // async read, also forwarded to execute
    output wb_t   wb,
    output logic  halt
);

    localparam int unsigned dmem_aw = $clog2(`DMEM_DEPTH);

    word_t dmem [`DMEM_DEPTH];
    mw_t   mw;

    assign load_data = dmem[em.alu_result[dmem_aw+1:2]]; // word addressed

    always_ff @(posedge clk) begin
        if (em.ctrl.mem_write) begin
            dmem[em.alu_result[dmem_aw+1:2]] <= em.store_data;
        end
    end

    // ==============================
    // memory/writeback register, halt set alongside the ecall entering it
    always_ff @(posedge clk) begin
        if (reset) begin
            mw.ctrl <= '0;
            halt    <= 1'b0;
        end else begin
            mw.ctrl <= em.ctrl;
            if (em.ctrl.halt) begin
                halt <= 1'b1;                // held until the next reset
            end
        end
        mw.alu_result <= em.alu_result;
        mw.load_data  <= load_data;
        mw.link_pc    <= em.link_pc;
        mw.rd         <= em.rd;
    end

    // writeback data select
    assign wb.valid = mw.ctrl.reg_write && mw.rd != '0;
    assign wb.rd    = mw.rd;
    assign wb.data  = mw.ctrl.mem_read ? mw.load_data :
                      mw.ctrl.sel_link ? mw.link_pc : mw.alu_result;

endmodule

// ==== riscv_cpu.sv ====
// rv32i five-stage pipeline core, top level
// fetch, decode, execute and memory/writeback, no stalls,
// forwarding into execute and a writeback bypass into decode

`timescale 1ns/1ps

module riscv_cpu
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  imem_load_t imem_load,  // program load, used during reset
    output wb_t        wb,         // register file write bus
    output logic       halt
);

    fd_t   fd;
    de_t   de;
    em_t   em;
    word_t load_data;
    logic  redirect;    // taken branch or jal in execute
    word_t target_pc;
    logic  halt_seen;

    fetch_stage u_fetch (
        .clk       (clk),
        .reset     (reset),
        .imem_load (imem_load),
        .redirect  (redirect),
        .target_pc (target_pc),
        .halt_seen (halt_seen),
        .fd        (fd)
    );

    decode_stage u_decode (
        .clk       (clk),
        .reset     (reset),
        .fd        (fd),
        .redirect  (redirect),
        .wb        (wb),
        .de        (de),
        .halt_seen (halt_seen)
    );

    execute_stage u_execute (
        .clk       (clk),
        .reset     (reset),
        .de        (de),
        .mem_fwd   (em),
        .load_data (load_data),
        .wb_fwd    (wb),
        .redirect  (redirect),
        .target_pc (target_pc),
        .em        (em)
    );

    memory_stage u_memory (
        .clk       (clk),
        .reset     (reset),
        .em        (em),
        .load_data (load_data),
        .wb        (wb),
        .halt      (halt)
    );

endmodule

// ==== tb_ref_model.svh ====
// reference model for the rv32i pipeline testbench
// builds the test programs and runs them sequentially to get the
// ordered list of register writes the core has to produce

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int    num_progs  = 3;
localparam int    prog_words = 64;            // words loaded per program
localparam int    max_writes = 32;
localparam word_t ecall_word = 32'h0000_0073;

integer    seed = 32'hba9d_2a37;
word_t     progs     [num_progs][prog_words];
int        prog_len;
int        build_idx;                         // program being built
reg_addr_t sel       [4];                     // distinct random registers
reg_addr_t left_reg;                          // left nonzero by program 0
reg_addr_t exp_rd    [num_progs][max_writes];
word_t     exp_data  [num_progs][max_writes];
int        exp_count [num_progs];
word_t     model_mem [word_t];                // byte address keyed

// ==============================
// instruction encoders in isa field order
function automatic word_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                 logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                 reg_addr_t rd, logic [6:0] opcode);
    return {imm, rs1, f3, rd, opcode};
endfunction

function automatic word_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}; // sw
endfunction

function automatic word_t b_type(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                 logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic word_t j_type(logic [20:0] off, reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111}; // jal
endfunction

function automatic word_t addi(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
    return i_type(imm, rs1, 3'b000, rd, 7'b0010011);
endfunction

function automatic word_t lw(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
    return i_type(imm, rs1, 3'b010, rd, 7'b0000011);
endfunction

function automatic void put(word_t w);
    progs[build_idx][prog_len] = w;
    prog_len++;
endfunction

// ==============================
// random operands
function automatic reg_addr_t rand_reg();
    logic [31:0] r;
    r = $random(seed);
    return (r[4:0] % 5'd31) + 5'd1; // x1..x31
endfunction

function automatic logic [11:0] rand_imm();
    logic [31:0] r;
    r = $random(seed);
    return {{4{r[7]}}, r[7:0]};     // small signed value
endfunction

function automatic void pick_regs();
    int        n;
    reg_addr_t r;
    logic      dup;
    n = 0;
    while (n < 4) begin
        r   = rand_reg();
        dup = 1'b0;
        for (int k = 0; k < n; k++) begin
            if (sel[k] == r) begin
                dup = 1'b1;
            end
        end
        if (!dup) begin
            sel[n] = r;
            n++;
        end
    end
endfunction

// ==============================
// program 0 is an alu chain with every result used one and two slots later
function automatic void build_alu();
    reg_addr_t a;
    reg_addr_t b;
    reg_addr_t c;
    reg_addr_t d;
    a = sel[0];
    b = sel[1];
    c = sel[2];
    d = sel[3];
    left_reg = b;                           // ends as d - 7, never zero
    put(addi(a, 5'd0, rand_imm()));
    put(addi(b, 5'd0, rand_imm()));
    put(r_type(7'h00, b, a, 3'b000, c));    // add c, a, b
    put(r_type(7'h20, a, c, 3'b000, d));    // sub d, c, a with a through the decode bypass
    put(r_type(7'h00, c, d, 3'b111, a));    // and a, d, c
    put(r_type(7'h00, d, a, 3'b110, b));    // or  b, a, d
    put(r_type(7'h00, a, b, 3'b010, c));    // slt c, b, a
    put(r_type(7'h00, b, a, 3'b010, d));    // slt d, a, b
    put(addi(5'd0, a, 12'h005));            // x0 write never seen on wb
    put(r_type(7'h00, d, 5'd0, 3'b000, a)); // add a, x0, d
    put(addi(b, a, 12'hff9));               // addi b, a, -7
    put(ecall_word);
endfunction

// program 1 stores, loads and uses a load result at once
function automatic void build_mem();
    reg_addr_t   p;
    reg_addr_t   v;
    reg_addr_t   w;
    reg_addr_t   u;
    logic [31:0] r;
    p = sel[0];
    v = sel[1];
    w = sel[2];
    u = sel[3];
    r = $random(seed);
    // word aligned base below 512, added to a register only reset clears
    put(addi(p, left_reg, {3'b000, r[6:0], 2'b00}));
    put(addi(v, 5'd0, rand_imm()));
    put(s_type(12'd0, v, p));               // sw v, 0(p)
    put(s_type(12'd4, p, p));               // sw p, 4(p)
    put(lw(w, p, 12'd0));
    put(r_type(7'h00, v, w, 3'b000, u));    // add u, w, v as a load-use
    put(lw(w, p, 12'd4));
    put(s_type(12'd8, u, p));               // sw u, 8(p)
    put(lw(v, p, 12'd8));                   // load right behind the store
    put(r_type(7'h20, w, v, 3'b000, u));    // sub u, v, w
    put(ecall_word);
endfunction

// program 2 takes beq and bne both ways, then jal
function automatic void build_branch();
    reg_addr_t   a;
    reg_addr_t   b;
    reg_addr_t   c;
    reg_addr_t   d;
    logic [11:0] val;
    a   = sel[0];
    b   = sel[1];
    c   = sel[2];
    d   = sel[3];
    val = rand_imm();
    put(addi(a, 5'd0, val));                // 0
    put(addi(b, 5'd0, val));                // 4
    put(b_type(13'd12, b, a, 3'b000));      // 8   beq taken to 20
    put(addi(c, 5'd0, 12'd1));              // 12  cancelled
    put(addi(c, 5'd0, 12'd2));              // 16  cancelled
    put(b_type(13'd8, b, a, 3'b001));       // 20  bne not taken
    put(addi(c, 5'd0, 12'd3));              // 24
    put(addi(b, b, 12'd1));                 // 28
    put(b_type(13'd12, b, a, 3'b001));      // 32  bne taken to 44
    put(addi(d, 5'd0, 12'd7));              // 36  cancelled
    put(addi(d, 5'd0, 12'd8));              // 40  cancelled
    put(b_type(13'd8, b, a, 3'b000));       // 44  beq not taken
    put(j_type(21'd12, d));                 // 48  jal to 60, d = 52
    put(addi(c, 5'd0, 12'd9));              // 52  cancelled
    put(addi(c, 5'd0, 12'd10));             // 56  cancelled
    put(r_type(7'h00, a, d, 3'b000, c));    // 60  add c, d, a
    put(ecall_word);
endfunction

// ==============================
// sequential isa model that returns the executed count including the ecall
function automatic int run_model(input int p);
    word_t     regs [32];
    word_t     pc;
    word_t     ins;
    word_t     a;
    word_t     b;
    word_t     res;
    word_t     next_pc;
    reg_addr_t rd;
    logic      writes;
    int        steps;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    model_mem.delete();
    exp_count[p] = 0;
    pc    = '0;
    steps = 0;
    while (steps < 500) begin
        ins = progs[p][pc[7:2]];
        steps++;
        if (ins[6:0] == 7'b1110011) break; // ecall ends the program
        a       = regs[ins[19:15]];
        b       = regs[ins[24:20]];
        rd      = ins[11:7];
        res     = '0;
        writes  = 1'b1;
        next_pc = pc + 32'd4;
        case (ins[6:0])
            7'b0110011: begin
                case (ins[14:12])
                    3'b000:  res = ins[30] ? a - b : a + b;
                    3'b111:  res = a & b;
                    3'b110:  res = a | b;
                    default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0; // slt
                endcase
            end
            7'b0010011: res = a + {{20{ins[31]}}, ins[31:20]};
            7'b0000011: res = model_mem[a + {{20{ins[31]}}, ins[31:20]}];
            7'b0100011: begin
                writes = 1'b0;
                model_mem[a + {{20{ins[31]}}, ins[31:25], ins[11:7]}] = b;
            end
            7'b1100011: begin
                writes = 1'b0;
                if ((ins[12] == 1'b0) == (a == b)) begin // beq on equal and bne otherwise
                    next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                    ins[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                res     = pc + 32'd4;
                next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                ins[30:21], 1'b0};
            end
            default: writes = 1'b0;
        endcase
        if (writes && rd != 5'd0) begin
            regs[rd] = res;
            exp_rd[p][exp_count[p]]   = rd;
            exp_data[p][exp_count[p]] = res;
            exp_count[p]++;
        end
        pc = next_pc;
    end
    return steps;
endfunction

function automatic int build_program(input int p);
    build_idx = p;
    prog_len  = 0;
    for (int i = 0; i < prog_words; i++) begin
        // register write per word, so any fetch past the ecall shows on wb
        progs[p][i] = addi(reg_addr_t'(i % 31 + 1), 5'd0, 12'(i));
    end
    pick_regs();
    case (p)
        0:       build_alu();
        1:       build_mem();
        default: build_branch();
    endcase
    return run_model(p);
endfunction

`endif

// ==== tb_riscv_cpu.sv ====
// testbench for the rv32i pipeline core
// loads each program during reset, checks every writeback strobe against
// the reference model and watches halt until the next reset

`timescale 1ns/1ps

module tb_riscv_cpu
    import cpu_pkg::*;
;

    logic       clk;
    logic       reset;
    imem_load_t imem_load;
    wb_t        wb;
    logic       halt;

    `include "tb_ref_model.svh"

    int   run_idx;          // program now running
    int   exp_idx;          // next expected write
    logic running;
    logic halt_was;
    int   reset_cycles;
    int   cycles;
    int   cycle_limit;
    int   value_errors;
    int   missing_errors;
    int   extra_errors;
    int   halt_errors;

    riscv_cpu DUT (
        .clk       (clk),
        .reset     (reset),
        .imem_load (imem_load),
        .wb        (wb),
        .halt      (halt)
    );

    always #20 clk = ~clk; // 40 ns period

    // ==============================
    // writeback and halt checks, sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            if (reset_cycles > 0) begin // wait for one reset edge
                assert (wb.valid == 1'b0) else begin
                    value_errors++;
                    $display("ERROR wb.valid: got 0x%h expected 0x0 during reset", wb.valid);
                end
                assert (halt == 1'b0) else begin
                    value_errors++;
                    $display("ERROR halt: got 0x%h expected 0x0 during reset", halt);
                end
            end
            reset_cycles++;
            exp_idx  = 0;
            halt_was = 1'b0;
        end else begin
            reset_cycles = 0;
            if (running) begin
                if (wb.valid) begin
                    assert (!halt) else begin
                        extra_errors++;
                        $display("register write after halt: x%0d written with 0x%08h",
                                 wb.rd, wb.data);
                    end
                    assert (halt || exp_idx < exp_count[run_idx]) else begin
                        extra_errors++;
                        $display("unexpected extra write to x%0d in program %0d",
                                 wb.rd, run_idx);
                    end
                    if (!halt && exp_idx < exp_count[run_idx]) begin
                        assert (wb.rd == exp_rd[run_idx][exp_idx]) else begin
                            value_errors++;
                            $display("ERROR wb.rd: got 0x%02h expected 0x%02h (program %0d, write %0d)",
                                     wb.rd, exp_rd[run_idx][exp_idx], run_idx, exp_idx);
                        end
                        assert (wb.data == exp_data[run_idx][exp_idx]) else begin
                            value_errors++;
                            $display("ERROR wb.data: got 0x%08h expected 0x%08h (program %0d, write %0d)",
                                     wb.data, exp_data[run_idx][exp_idx], run_idx, exp_idx);
                        end
                        exp_idx++;
                    end
                end
                if (halt && !halt_was) begin // all writes must be out first
                    assert (exp_idx == exp_count[run_idx]) else begin
                        missing_errors += exp_count[run_idx] - exp_idx;
                        $display("halt raised with only %0d of %0d expected writes seen",
                                 exp_idx, exp_count[run_idx]);
                    end
                end
                assert (halt || !halt_was) else begin
                    halt_errors++;
                    $display("halt dropped before reset in program %0d", run_idx);
                end
                halt_was = halt;
            end
        end
    end

    // timeout, counts cycles out of reset only
    always @(posedge clk) begin
        if (!reset) begin
            cycles++;
            if (cycles >= cycle_limit) begin
                $display("timeout: core still running after %0d cycles", cycle_limit);
                $display("TEST FAIL");
                $finish;
            end
        end
    end

    // load over imem_load while reset is high, release, wait for halt
    task automatic run_program(input int p);
        @(posedge clk);
        #1;
        reset   = 1'b1;
        running = 1'b0;
        for (int i = 0; i < prog_words; i++) begin
            imem_load.valid = 1'b1;
            imem_load.addr  = 8'(i);
            imem_load.data  = progs[p][i];
            @(posedge clk);
            #1;
        end
        imem_load = '0;
        repeat (8) @(posedge clk); // reset held 8 more cycles
        #1;
        run_idx = p;
        running = 1'b1;
        reset   = 1'b0;
        @(negedge clk);
        while (!halt) @(negedge clk);
        repeat (4) @(negedge clk); // no strobe allowed after halt
    endtask

    // ==============================
    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        imem_load      = '0;
        running        = 1'b0;
        run_idx        = 0;
        cycles         = 0;
        cycle_limit    = 0;
        value_errors   = 0;
        missing_errors = 0;
        extra_errors   = 0;
        halt_errors    = 0;
        for (int p = 0; p < num_progs; p++) begin
            cycle_limit += build_program(p) + 20; // executed count from the model
        end
        for (int p = 0; p < num_progs; p++) begin
            run_program(p);
        end
        $display("errors: %0d value, %0d missing writes, %0d extra writes, %0d halt",
                 value_errors, missing_errors, extra_errors, halt_errors);
        if (value_errors + missing_errors + extra_errors + halt_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
cpu_pkg.sv
instr_decoder.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
riscv_cpu.sv
tb_riscv_cpu.sv

// ==== Makefile ====
# Verilator build and run for the rv32i pipeline core testbench

LOG = sim.log

.PHONY: sim lint clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f --top-module tb_riscv_cpu -Mdir obj_dir
	./obj_dir/Vtb_riscv_cpu | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f compile.f --top-module tb_riscv_cpu

clean:
	rm -rf obj_dir $(LOG)
